// File: design/bank_rr_arbiter.sv
// Round-robin arbiter that picks one master request aimed at a single bank.
`timescale 1ns/1ps

module bank_rr_arbiter (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [spm_cfg_pkg::N_MASTER-1:0]   req_i,
  output logic [spm_cfg_pkg::N_MASTER-1:0]   gnt_o
);

  import spm_cfg_pkg::*;

  // Highest priority master for the next decision.
  logic [ID_W-1:0] ptr_q;
  logic [ID_W-1:0] ptr_d;

  // Search from the pointer, wrapping around.
  // First hit wins, later ones are ignored.
  always_comb begin : grant_search
    logic        found;
    int unsigned idx;
    found = 1'b0;
    idx   = 0;
    gnt_o = '0;
    ptr_d = ptr_q;
    for (int unsigned off = 0; off < N_MASTER; off++) begin
      idx = (ptr_q + off) % N_MASTER;
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        gnt_o[idx] = 1'b1;
        // Winner drops to lowest priority.
        ptr_d      = ID_W'((idx + 1) % N_MASTER);
      end
    end
  end

  // Pointer register.
  // Unchanged in cycles without a grant.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

// File: design/l1_spm.sv
// L1 scratchpad, an array of SRAM banks that always grant and echo the request ID.
`timescale 1ns/1ps

module l1_spm (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  spm_bus_pkg::bank_req_t [spm_cfg_pkg::N_BANK-1:0]   bank_req_i,
  output spm_bus_pkg::bank_rsp_t [spm_cfg_pkg::N_BANK-1:0]   bank_rsp_o
);

  import spm_cfg_pkg::*;
  import spm_bus_pkg::*;

  for (genvar b = 0; b < N_BANK; b++) begin : gen_bank
    // Response side state of this bank.
    logic              r_valid_q;
    logic [ID_W-1:0]   r_id_q;
    logic [DATA_W-1:0] rdata;
    logic              we;

    // Bus uses wen high for read.
    assign we = ~bank_req_i[b].wen;

    // Every accepted request answers next cycle.
    // The ID only moves on a request.
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        r_valid_q <= 1'b0;
        r_id_q    <= '0;
      end else begin
        r_valid_q <= bank_req_i[b].req;
        if (bank_req_i[b].req) begin
          r_id_q <= bank_req_i[b].id;
        end
      end
    end

    spm_sram_bank #(
      .sim_init ( "ones" )
    ) i_sram_bank (
      .clk_i   ( clk_i               ),
      .rst_ni  ( rst_ni              ),
      .req_i   ( bank_req_i[b].req   ),
      .we_i    ( we                  ),
      .addr_i  ( bank_req_i[b].word  ),
      .wdata_i ( bank_req_i[b].wdata ),
      .be_i    ( bank_req_i[b].be    ),
      .rdata_o ( rdata               )
    );

    // Data, valid and ID line up in the same cycle.
    assign bank_rsp_o[b] = '{
      r_valid: r_valid_q,
      r_data:  rdata,
      r_id:    r_id_q
    };
  end

endmodule

// File: design/spm_bus_pkg.sv
// Request and response structs of the master side and bank side buses.
package spm_bus_pkg;

  import spm_cfg_pkg::*;

  // Master request.
  // Fields stay stable until gnt is seen.
  typedef struct packed {
    logic              req;
    // High means read, low means write.
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } mst_req_t;

  // Master response.
  // gnt is combinational, r_valid one cycle after the grant.
  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
  } mst_rsp_t;

  // Bank request after decode and arbitration.
  typedef struct packed {
    logic              req;
    logic              wen;
    logic [WORD_W-1:0] word;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    // Index of the granted master.
    logic [ID_W-1:0]   id;
  } bank_req_t;

  // Bank response with the echoed ID.
  typedef struct packed {
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic [ID_W-1:0]   r_id;
  } bank_rsp_t;

endpackage

// File: design/spm_cfg_pkg.sv
// Memory geometry and derived field widths of the L1 scratchpad.
package spm_cfg_pkg;

  // Number of master ports on the crossbar.
  localparam int unsigned N_MASTER = 4;
  // Number of interleaved banks.
  localparam int unsigned N_BANK = 8;
  // Words in each bank.
  localparam int unsigned N_WORDS = 64;

  // Word width in bits.
  localparam int unsigned DATA_W = 32;
  // One enable per byte lane.
  localparam int unsigned BE_W = DATA_W / 8;
  // Byte address seen by the masters.
  localparam int unsigned ADDR_W = 16;

  // Bank select field width.
  localparam int unsigned BANK_W = $clog2(N_BANK);
  // Word index inside one bank.
  localparam int unsigned WORD_W = $clog2(N_WORDS);
  // Request ID carries the master index.
  localparam int unsigned ID_W = $clog2(N_MASTER);

  // Byte offset sits below the bank field.
  localparam int unsigned BANK_LSB = 2;
  // Word index starts right above the bank field.
  // Address bits above it are not decoded and alias.
  localparam int unsigned WORD_LSB = BANK_LSB + BANK_W;

endpackage

// File: design/spm_sram_bank.sv
// Single-port SRAM bank with byte enables and a one-cycle read latency.
`timescale 1ns/1ps

module spm_sram_bank #(
  // Simulation start value, "ones" or "zeros".
  parameter sim_init = "ones"
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [spm_cfg_pkg::WORD_W-1:0]   addr_i,
  input  logic [spm_cfg_pkg::DATA_W-1:0]   wdata_i,
  input  logic [spm_cfg_pkg::BE_W-1:0]     be_i,
  output logic [spm_cfg_pkg::DATA_W-1:0]   rdata_o
);

  import spm_cfg_pkg::*;

  // Fill word picked from sim_init.
  localparam logic [DATA_W-1:0] init_word = (sim_init == "zeros") ? '0 : '1;

  // Storage array.
  logic [DATA_W-1:0] mem [N_WORDS];
  logic [DATA_W-1:0] rdata_q;

  // Simulation start state of the array.
  initial begin
    for (int unsigned w = 0; w < N_WORDS; w++) begin
      mem[w] = init_word;
    end
  end

  // Write port.
  // Only enabled byte lanes change.
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned i = 0; i < BE_W; i++) begin
        if (be_i[i]) begin
          mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // Read register.
  // Any access samples the old word, so a write returns the value before it.
  // Holds its value between accesses.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= mem[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: design/spm_subsystem_top.sv
// Scratchpad subsystem top, crossbar in front of the banked L1 memory.
`timescale 1ns/1ps

module spm_subsystem_top (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  spm_bus_pkg::mst_req_t [spm_cfg_pkg::N_MASTER-1:0]   mst_req_i,
  output spm_bus_pkg::mst_rsp_t [spm_cfg_pkg::N_MASTER-1:0]   mst_rsp_o
);

  import spm_cfg_pkg::*;
  import spm_bus_pkg::*;

  // Bank side bus between crossbar and memory.
  bank_req_t [N_BANK-1:0] bank_req;
  bank_rsp_t [N_BANK-1:0] bank_rsp;

  // Decode, arbitration and response routing.
  tcdm_xbar i_tcdm_xbar (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .mst_req_i  ( mst_req_i ),
    .mst_rsp_o  ( mst_rsp_o ),
    .bank_req_o ( bank_req  ),
    .bank_rsp_i ( bank_rsp  )
  );

  // Banks answer one cycle after the request.
  l1_spm i_l1_spm (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .bank_req_i ( bank_req ),
    .bank_rsp_o ( bank_rsp )
  );

endmodule

// File: design/tcdm_xbar.sv
// Crossbar from masters to interleaved banks, with per-bank round-robin and ID routing.
`timescale 1ns/1ps

module tcdm_xbar (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  spm_bus_pkg::mst_req_t  [spm_cfg_pkg::N_MASTER-1:0]   mst_req_i,
  output spm_bus_pkg::mst_rsp_t  [spm_cfg_pkg::N_MASTER-1:0]   mst_rsp_o,
  output spm_bus_pkg::bank_req_t [spm_cfg_pkg::N_BANK-1:0]     bank_req_o,
  input  spm_bus_pkg::bank_rsp_t [spm_cfg_pkg::N_BANK-1:0]     bank_rsp_i
);

  import spm_cfg_pkg::*;
  import spm_bus_pkg::*;

  // Decoded target of each master.
  logic [N_MASTER-1:0][BANK_W-1:0] bank_idx;
  logic [N_MASTER-1:0][WORD_W-1:0] word_idx;

  // Request and grant matrices, one row per bank.
  logic [N_BANK-1:0][N_MASTER-1:0] arb_req;
  logic [N_BANK-1:0][N_MASTER-1:0] arb_gnt;

  // Grant seen by each master.
  logic [N_MASTER-1:0] mst_gnt;

  // Address decode.
  // Bank field right above the byte offset, word index above that.
  for (genvar m = 0; m < N_MASTER; m++) begin : gen_decode
    assign bank_idx[m] = mst_req_i[m].addr[BANK_LSB +: BANK_W];
    assign word_idx[m] = mst_req_i[m].addr[WORD_LSB +: WORD_W];
  end

  for (genvar b = 0; b < N_BANK; b++) begin : gen_bank
    // Requests that target this bank.
    for (genvar m = 0; m < N_MASTER; m++) begin : gen_req
      assign arb_req[b][m] = mst_req_i[m].req && (bank_idx[m] == BANK_W'(b));
    end

    bank_rr_arbiter i_bank_rr_arbiter (
      .clk_i  ( clk_i      ),
      .rst_ni ( rst_ni     ),
      .req_i  ( arb_req[b] ),
      .gnt_o  ( arb_gnt[b] )
    );
  end

  // Bank request mux.
  // Grant is one-hot, so at most one master drives a bank.
  always_comb begin
    for (int unsigned b = 0; b < N_BANK; b++) begin
      bank_req_o[b] = '0;
      for (int unsigned m = 0; m < N_MASTER; m++) begin
        if (arb_gnt[b][m]) begin
          bank_req_o[b].req   = 1'b1;
          bank_req_o[b].wen   = mst_req_i[m].wen;
          bank_req_o[b].word  = word_idx[m];
          bank_req_o[b].wdata = mst_req_i[m].wdata;
          bank_req_o[b].be    = mst_req_i[m].be;
          // ID is the master index.
          bank_req_o[b].id    = ID_W'(m);
        end
      end
    end
  end

  // A master targets one bank, so OR over banks is its grant.
  always_comb begin
    mst_gnt = '0;
    for (int unsigned b = 0; b < N_BANK; b++) begin
      mst_gnt = mst_gnt | arb_gnt[b];
    end
  end

  // Response routing by echoed ID.
  // Only one bank answers a given master per cycle.
  always_comb begin
    for (int unsigned m = 0; m < N_MASTER; m++) begin
      mst_rsp_o[m]     = '0;
      mst_rsp_o[m].gnt = mst_gnt[m];
      for (int unsigned b = 0; b < N_BANK; b++) begin
        if (bank_rsp_i[b].r_valid && (bank_rsp_i[b].r_id == ID_W'(m))) begin
          mst_rsp_o[m].r_valid = 1'b1;
          mst_rsp_o[m].r_data  = bank_rsp_i[b].r_data;
        end
      end
    end
  end

endmodule

// File: sim.f
design/spm_cfg_pkg.sv
design/spm_bus_pkg.sv
design/spm_sram_bank.sv
design/bank_rr_arbiter.sv
design/l1_spm.sv
design/tcdm_xbar.sv
design/spm_subsystem_top.sv
tb/spm_assertions.sv
tb/spm_tb.sv

// File: tb/spm_assertions.sv
// Protocol assertions on the master ports of the scratchpad subsystem.
`timescale 1ns/1ps

module spm_assertions (
  input logic                                                clk_i,
  input logic                                                rst_ni,
  input spm_bus_pkg::mst_req_t [spm_cfg_pkg::N_MASTER-1:0]   mst_req_i,
  input spm_bus_pkg::mst_rsp_t [spm_cfg_pkg::N_MASTER-1:0]   mst_rsp_o
);

  import spm_cfg_pkg::*;
  import spm_bus_pkg::*;

  // Failed assertions so far.
  int unsigned assert_errors = 0;
  // Two granted masters aiming at one bank.
  logic bank_clash;

  always_comb begin
    bank_clash = 1'b0;
    for (int unsigned a = 0; a < N_MASTER; a++) begin
      for (int unsigned b = a + 1; b < N_MASTER; b++) begin
        if (mst_rsp_o[a].gnt && mst_rsp_o[b].gnt &&
            (mst_req_i[a].addr[BANK_LSB +: BANK_W] == mst_req_i[b].addr[BANK_LSB +: BANK_W])) begin
          bank_clash = 1'b1;
        end
      end
    end
  end

  one_grant_per_bank: assert property (@(posedge clk_i) disable iff (!rst_ni) !bank_clash)
    else begin
      $error("two masters granted the same bank in one cycle");
      assert_errors++;
    end

  for (genvar m = 0; m < N_MASTER; m++) begin : gen_port
    gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_rsp_o[m].gnt |-> mst_req_i[m].req)
      else begin
        $error("gnt without req on master %0d", m);
        assert_errors++;
      end

    // Response exactly one cycle after the grant, and never otherwise.
    valid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_rsp_o[m].gnt |=> mst_rsp_o[m].r_valid)
      else begin
        $error("no r_valid one cycle after gnt on master %0d", m);
        assert_errors++;
      end

    valid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_rsp_o[m].r_valid |-> $past(mst_rsp_o[m].gnt))
      else begin
        $error("r_valid without a grant one cycle earlier on master %0d", m);
        assert_errors++;
      end

    valid_low_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !mst_rsp_o[m].r_valid)
      else begin
        $error("r_valid high during reset on master %0d", m);
        assert_errors++;
      end
  end

endmodule

bind spm_subsystem_top spm_assertions i_spm_assertions (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .mst_req_i ( mst_req_i ),
  .mst_rsp_o ( mst_rsp_o )
);

// File: tb/spm_tb.sv
// Testbench that runs random traffic on the scratchpad subsystem against a reference memory model.
`timescale 1ns/1ps

module spm_tb;

  import spm_cfg_pkg::*;
  import spm_bus_pkg::*;

  // Cycles a master waits for gnt.
  localparam int unsigned GNT_TIMEOUT = 20;
  // Cycles allowed for the last responses.
  localparam int unsigned DRAIN_TIMEOUT = 10;
  localparam int unsigned MODEL_WORDS = N_BANK * N_WORDS;
  // Address bits above the decoded fields.
  localparam int unsigned ALIAS_LSB = WORD_LSB + WORD_W;
  localparam int unsigned ALIAS_W = ADDR_W - ALIAS_LSB;

  // Expected response of one transfer.
  typedef struct packed {
    logic              is_read;
    logic [DATA_W-1:0] data;
  } exp_t;

  logic                    clk_i;
  logic                    rst_ni;
  mst_req_t [N_MASTER-1:0] mst_req;
  mst_rsp_t [N_MASTER-1:0] mst_rsp;

  logic [15:0]       lfsr_q;
  logic [DATA_W-1:0] model_mem [MODEL_WORDS];
  exp_t              exp_q [N_MASTER][$];
  int unsigned       grant_cycles [N_MASTER];
  // Expected round-robin pointer of each bank.
  logic [ID_W-1:0]   rr_ptr [N_BANK];

  int unsigned data_errors = 0;
  int unsigned valid_errors = 0;
  int unsigned grant_errors = 0;
  int unsigned timeout_errors = 0;

  spm_subsystem_top spm_subsystem_top_i (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .mst_req_i ( mst_req ),
    .mst_rsp_o ( mst_rsp )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Fibonacci step with taps 16 14 13 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Reference write where enabled bytes replace the old ones.
  function automatic logic [DATA_W-1:0] merge_word(input logic [DATA_W-1:0] old_word,
                                                   input logic [DATA_W-1:0] wdata,
                                                   input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int unsigned i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Word slot of an address.
  // Consecutive words land in consecutive banks and upper bits alias.
  function automatic int unsigned model_index(input logic [ADDR_W-1:0] addr);
    return (int'(addr) / BE_W) % MODEL_WORDS;
  endfunction

  function automatic int unsigned pending();
    int unsigned n;
    n = 0;
    for (int m = 0; m < N_MASTER; m++) begin
      n += exp_q[m].size();
    end
    return n;
  endfunction

  // Compares responses and then records this cycle's transfers.
  always @(negedge clk_i) begin : compare
    exp_t e;
    exp_t nxt;
    logic exp_valid;
    int unsigned idx;
    for (int m = 0; m < N_MASTER; m++) begin
      exp_valid = (exp_q[m].size() != 0);
      if (!rst_ni) begin
        exp_valid = 1'b0;
      end
      if (mst_rsp[m].r_valid !== exp_valid) begin
        $display("ERROR master %0d r_valid: got %h, expected %h", m,
                 mst_rsp[m].r_valid, exp_valid);
        valid_errors++;
      end
      if (rst_ni && exp_valid) begin
        e = exp_q[m].pop_front();
        if (e.is_read && (mst_rsp[m].r_data !== e.data)) begin
          $display("ERROR master %0d r_data: got %h, expected %h", m,
                   mst_rsp[m].r_data, e.data);
          data_errors++;
        end
      end
      if (!mst_req[m].req && (mst_rsp[m].gnt !== 1'b0)) begin
        $display("ERROR master %0d gnt: got %h, expected %h", m, mst_rsp[m].gnt, 1'b0);
        grant_errors++;
      end
      if (rst_ni && mst_req[m].req && (mst_rsp[m].gnt === 1'b1)) begin
        idx = model_index(mst_req[m].addr);
        nxt.is_read = mst_req[m].wen;
        nxt.data = model_mem[idx];
        if (!mst_req[m].wen) begin
          model_mem[idx] = merge_word(model_mem[idx], mst_req[m].wdata, mst_req[m].be);
        end
        exp_q[m].push_back(nxt);
        // Pointer of the target bank moves past the winner.
        rr_ptr[mst_req[m].addr[BANK_LSB +: BANK_W]] = ID_W'((m + 1) % N_MASTER);
      end
    end
  end

  // Holds one request until gnt and returns the cycles it took.
  // Called 1 ns after a rising edge and returns at the same point.
  task automatic issue(input int m, input logic wen, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                       output int unsigned cycles);
    logic granted;
    granted = 1'b0;
    cycles = 0;
    mst_req[m].wen = wen;
    mst_req[m].addr = addr;
    mst_req[m].wdata = wdata;
    mst_req[m].be = be;
    mst_req[m].req = 1'b1;
    while (!granted && (cycles < GNT_TIMEOUT)) begin
      @(negedge clk_i);
      granted = (mst_rsp[m].gnt === 1'b1);
      cycles++;
      @(posedge clk_i);
      #1;
    end
    mst_req[m].req = 1'b0;
    if (!granted) begin
      $display("Master %0d was not granted within %0d cycles", m, GNT_TIMEOUT);
      timeout_errors++;
    end
  endtask

  // All masters present a request in the same cycle.
  task automatic burst(input logic [N_MASTER-1:0]             rd,
                       input logic [N_MASTER-1:0][ADDR_W-1:0] addrs,
                       input logic [N_MASTER-1:0][DATA_W-1:0] wdatas,
                       input logic [N_MASTER-1:0][BE_W-1:0]   bes);
    for (int m = 0; m < N_MASTER; m++) begin
      fork
        automatic int mm = m;
        issue(mm, rd[mm], addrs[mm], wdatas[mm], bes[mm], grant_cycles[mm]);
      join_none
    end
    wait fork;
  endtask

  task automatic check_grants(input int unsigned limit);
    for (int m = 0; m < N_MASTER; m++) begin
      if (grant_cycles[m] > limit) begin
        $display("ERROR master %0d grant_cycles: got %h, expected at most %h", m,
                 grant_cycles[m], limit);
        grant_errors++;
      end
    end
  endtask

  // Round-robin from ptr grants ptr first and each following master one cycle later.
  task automatic check_rr_order(input int unsigned ptr);
    int unsigned exp_cycles;
    for (int m = 0; m < N_MASTER; m++) begin
      exp_cycles = ((m + N_MASTER - ptr) % N_MASTER) + 1;
      if (grant_cycles[m] != exp_cycles) begin
        $display("ERROR master %0d grant_cycles: got %h, expected %h", m,
                 grant_cycles[m], exp_cycles);
        grant_errors++;
      end
    end
  endtask

  initial begin : main
    logic [N_MASTER-1:0]             rd;
    logic [N_MASTER-1:0][ADDR_W-1:0] addrs;
    logic [N_MASTER-1:0][DATA_W-1:0] wdatas;
    logic [N_MASTER-1:0][BE_W-1:0]   bes;
    logic [ADDR_W-1:0]               addr;
    logic [ADDR_W-1:0]               alias_addr;
    logic [DATA_W-1:0]               wdata;
    logic [BE_W-1:0]                 be;
    logic [BANK_W-1:0]               bank;
    int unsigned                     start_ptr;
    int unsigned                     cycles;
    int unsigned                     waited;
    int unsigned                     total;
    lfsr_q = 16'd12443;
    rst_ni = 1'b0;
    mst_req = '0;
    for (int i = 0; i < MODEL_WORDS; i++) begin
      model_mem[i] = '1;
    end
    for (int b = 0; b < N_BANK; b++) begin
      rr_ptr[b] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Idle cycles with no grants and no responses.
    repeat (3) @(posedge clk_i);
    #1;
    // Reads before any write see the fill value.
    for (int i = 0; i < 8; i++) begin
      issue(0, 1'b1, ADDR_W'(rand_bits(ADDR_W)), '0, '1, cycles);
    end
    // Single master writes with random byte enables and reads back.
    for (int i = 0; i < 12; i++) begin
      addr = ADDR_W'(rand_bits(ADDR_W));
      be = BE_W'(rand_bits(BE_W));
      wdata = rand_bits(DATA_W);
      issue(0, 1'b0, addr, wdata, be, cycles);
      issue(0, 1'b1, addr, '0, '1, cycles);
    end
    // Consecutive words from one base fall in distinct banks.
    for (int r = 0; r < 6; r++) begin
      addr = ADDR_W'(rand_bits(ADDR_W));
      for (int m = 0; m < N_MASTER; m++) begin
        addrs[m] = addr + ADDR_W'(BE_W * m);
        wdatas[m] = rand_bits(DATA_W);
        bes[m] = BE_W'(rand_bits(BE_W));
      end
      burst('0, addrs, wdatas, bes);
      check_grants(1);
      burst('1, addrs, wdatas, bes);
      check_grants(1);
    end
    // All masters on one bank with differing words and alias bits.
    for (int r = 0; r < 10; r++) begin
      bank = BANK_W'(rand_bits(BANK_W));
      start_ptr = rr_ptr[bank];
      for (int m = 0; m < N_MASTER; m++) begin
        addrs[m] = ADDR_W'(rand_bits(ADDR_W));
        addrs[m][BANK_LSB +: BANK_W] = bank;
        rd[m] = 1'(rand_bits(1));
        wdatas[m] = rand_bits(DATA_W);
        bes[m] = BE_W'(rand_bits(BE_W));
      end
      burst(rd, addrs, wdatas, bes);
      check_rr_order(start_ptr);
    end
    // Write through one alias and read through another.
    for (int i = 0; i < 8; i++) begin
      addr = ADDR_W'(rand_bits(ADDR_W));
      alias_addr = addr ^ (ADDR_W'(rand_bits(ALIAS_W) | 1) << ALIAS_LSB);
      issue(1, 1'b0, addr, rand_bits(DATA_W), BE_W'(rand_bits(BE_W)), cycles);
      issue(1, 1'b1, alias_addr, '0, '1, cycles);
    end
    // Let the last responses arrive.
    waited = 0;
    while ((pending() != 0) && (waited < DRAIN_TIMEOUT)) begin
      @(posedge clk_i);
      waited++;
    end
    if (pending() != 0) begin
      $display("Responses still outstanding after %0d cycles", DRAIN_TIMEOUT);
      timeout_errors++;
    end
    @(posedge clk_i);
    total = data_errors + valid_errors + grant_errors + timeout_errors +
            spm_subsystem_top_i.i_spm_assertions.assert_errors;
    $display("Errors: data %0d, valid %0d, grant %0d, timeout %0d, assertion %0d",
             data_errors, valid_errors, grant_errors, timeout_errors,
             spm_subsystem_top_i.i_spm_assertions.assert_errors);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
